// ==== common/phase_align_pkg.sv ====
package phase_align_pkg;

	//////////////////////////////////////////////////////////////////////
	// Sizing

	// Captured words per measurement window
	localparam int MEASURE_CYCLES = 32;

	// Window counter width, counts 0 .. MEASURE_CYCLES-1
	localparam int MEAS_CNT_WIDTH = $clog2(MEASURE_CYCLES);

	// Stable steps since the last edge
	localparam int BUMP_WIDTH = 10;

	// Step-back counter holds at most half the bump count
	localparam int STEP_WIDTH = BUMP_WIDTH - 1;

	// Deserialized loopback word, four bits per fabric clock
	localparam int WORD_WIDTH = 4;

	//////////////////////////////////////////////////////////////////////
	// Encodings

	// Marker position seen in the loopback word
	// Anything that is not one-hot counts as unstable
	typedef enum logic [2:0] {
		MEAS_0001     = 3'd0,
		MEAS_0010     = 3'd1,
		MEAS_0100     = 3'd2,
		MEAS_1000     = 3'd3,
		MEAS_UNSTABLE = 3'd4
	} measurement_t;

	// Phase search FSM
	typedef enum logic [2:0] {
		IDLE       = 3'd0,
		MEASURE    = 3'd1,
		DECIDE     = 3'd2,
		SHIFT_WAIT = 3'd3,
		ALIGNED    = 3'd4
	} search_state_t;

	//////////////////////////////////////////////////////////////////////
	// Bundles

	// Result of one measurement window
	// valid is a single-cycle strobe
	typedef struct packed {
		logic         valid;
		measurement_t meas;
	} window_result_t;

	// MMCM phase shift request
	// inc only matters while en is high
	typedef struct packed {
		logic en;
		logic inc;
	} phase_shift_cmd_t;

endpackage

// ==== phase_align/word_stability_checker.sv ====
`timescale 1ns/1ps

module word_stability_checker(
	input wire                                   clk_312p5mhz,
	input wire                                   serdes_rst,
	input wire [phase_align_pkg::WORD_WIDTH-1:0] loopback_word,
	input wire                                   measure_start,
	output phase_align_pkg::window_result_t      window_result
);

	//////////////////////////////////////////////////////////////////////
	// Capture and classify

	// Loopback word register
	logic [phase_align_pkg::WORD_WIDTH-1:0] word_q;

	// Current classification
	phase_align_pkg::measurement_t cur_meas;

	// Running window classification
	phase_align_pkg::measurement_t acc_meas;
	phase_align_pkg::measurement_t next_meas;

	// Window control
	logic                                       arm;
	logic                                       win_open;
	logic [phase_align_pkg::MEAS_CNT_WIDTH-1:0] win_cnt;
	logic                                       win_last;
	logic                                       result_valid;

	always_ff @(posedge clk_312p5mhz) begin
		word_q <= loopback_word;
	end

	// Exactly one marker bit means a clean sample
	always_comb begin
		case (word_q)
			4'b0001: cur_meas = phase_align_pkg::MEAS_0001;
			4'b0010: cur_meas = phase_align_pkg::MEAS_0010;
			4'b0100: cur_meas = phase_align_pkg::MEAS_0100;
			4'b1000: cur_meas = phase_align_pkg::MEAS_1000;
			default: cur_meas = phase_align_pkg::MEAS_UNSTABLE;
		endcase
	end

	//////////////////////////////////////////////////////////////////////
	// Window accumulation

	// First word seeds the window
	// Any later mismatch marks the whole window unstable
	always_comb begin
		if (win_cnt == '0)
			next_meas = cur_meas;
		else if (cur_meas != acc_meas)
			next_meas = phase_align_pkg::MEAS_UNSTABLE;
		else
			next_meas = acc_meas;
	end

	assign win_last = (win_cnt == phase_align_pkg::MEAS_CNT_WIDTH'(
		phase_align_pkg::MEASURE_CYCLES - 1));

	// Start is armed one cycle so the window opens on the
	// word registered after the start edge
	always_ff @(posedge clk_312p5mhz) begin
		if (serdes_rst) begin
			arm          <= 1'b0;
			win_open     <= 1'b0;
			win_cnt      <= '0;
			result_valid <= 1'b0;
		end
		else begin
			result_valid <= 1'b0;
			arm          <= measure_start;

			if (arm) begin
				win_open <= 1'b1;
				win_cnt  <= '0;
			end
			else if (win_open) begin
				win_cnt <= win_cnt + 1'b1;

				// Last word, report next cycle
				if (win_last) begin
					win_open     <= 1'b0;
					result_valid <= 1'b1;
				end
			end
		end
	end

	always_ff @(posedge clk_312p5mhz) begin
		if (win_open)
			acc_meas <= next_meas;
	end

	always_comb begin
		window_result.valid = result_valid;
		window_result.meas  = acc_meas;
	end

	//////////////////////////////////////////////////////////////////////
	// Checks

	// Search FSM must wait for the result before starting again
	a_no_start_in_window: assert property (@(posedge clk_312p5mhz)
		disable iff (serdes_rst)
		measure_start |-> !(arm || win_open));

endmodule

// ==== phase_align/phase_search_fsm.sv ====
`timescale 1ns/1ps

module phase_search_fsm(
	input wire                                   clk_312p5mhz,
	input wire                                   serdes_rst,
	input wire phase_align_pkg::window_result_t  window_result,
	input wire                                   phase_shift_done,
	output logic                                 measure_start,
	output phase_align_pkg::phase_shift_cmd_t    phase_shift,
	output logic                                 done
);

	//////////////////////////////////////////////////////////////////////
	// State

	phase_align_pkg::search_state_t state;

	// Last window result, consumed in DECIDE
	phase_align_pkg::measurement_t result_q;

	// First unstable edge found since the search started
	logic first_edge;

	// At least one stable window since the last edge
	logic seen_stable;

	// Walking back toward the middle of the stable window
	logic stepping_back;

	// Stable steps since the last edge, plus one for the edge itself
	logic [phase_align_pkg::BUMP_WIDTH-1:0] bump_cnt;

	// Decrement shifts still to issue after the current one
	logic [phase_align_pkg::STEP_WIDTH-1:0] steps_left;

	// Decode of the latched result
	logic result_stable;
	logic second_edge;

	always_comb begin
		result_stable = (result_q != phase_align_pkg::MEAS_UNSTABLE);

		// Unstable again after some stable windows closes the eye
		second_edge = !result_stable && first_edge && seen_stable;
	end

	//////////////////////////////////////////////////////////////////////
	// Shift command

	// DECIDE is the one cycle that issues a shift
	// Searching moves forward, stepping back moves backward
	always_comb begin
		phase_shift.en  = (state == phase_align_pkg::DECIDE);
		phase_shift.inc = !stepping_back && !second_edge;
	end

	//////////////////////////////////////////////////////////////////////
	// Search FSM

	always_ff @(posedge clk_312p5mhz) begin
		if (serdes_rst) begin
			state         <= phase_align_pkg::IDLE;
			measure_start <= 1'b0;
			done          <= 1'b0;
			first_edge    <= 1'b0;
			seen_stable   <= 1'b0;
			stepping_back <= 1'b0;
			bump_cnt      <= '0;
			steps_left    <= '0;
		end
		else begin
			measure_start <= 1'b0;

			case (state)

				// Fresh search out of reset
				phase_align_pkg::IDLE: begin
					first_edge    <= 1'b0;
					seen_stable   <= 1'b0;
					stepping_back <= 1'b0;
					bump_cnt      <= '0;
					measure_start <= 1'b1;
					state         <= phase_align_pkg::MEASURE;
				end

				// Window running in the checker
				phase_align_pkg::MEASURE: begin
					if (window_result.valid)
						state <= phase_align_pkg::DECIDE;
				end

				// Apply the search rule, one shift goes out either way
				phase_align_pkg::DECIDE: begin
					state <= phase_align_pkg::SHIFT_WAIT;

					if (stepping_back)
						steps_left <= steps_left - 1'b1;

					// Stable, keep walking through the eye
					else if (result_stable) begin
						bump_cnt    <= bump_cnt + 1'b1;
						seen_stable <= 1'b1;
					end

					// Second edge, this shift is the first of floor(B/2)
					else if (second_edge) begin
						steps_left    <= bump_cnt[phase_align_pkg::BUMP_WIDTH-1:1] - 1'b1;
						stepping_back <= 1'b1;
					end

					// First edge, or more of it
					else begin
						first_edge  <= 1'b1;
						seen_stable <= 1'b0;
						bump_cnt    <= 1;
					end
				end

				// MMCM busy until phase_shift_done
				phase_align_pkg::SHIFT_WAIT: begin
					if (phase_shift_done) begin
						if (!stepping_back) begin
							measure_start <= 1'b1;
							state         <= phase_align_pkg::MEASURE;
						end
						else if (steps_left != '0)
							state <= phase_align_pkg::DECIDE;

						// Centered, start monitoring
						else begin
							done          <= 1'b1;
							measure_start <= 1'b1;
							state         <= phase_align_pkg::ALIGNED;
						end
					end
				end

				// Back-to-back windows while locked
				phase_align_pkg::ALIGNED: begin
					if (window_result.valid) begin
						if (window_result.meas == phase_align_pkg::MEAS_UNSTABLE) begin
							// Lost the eye, this result is a new first edge
							done          <= 1'b0;
							first_edge    <= 1'b0;
							seen_stable   <= 1'b0;
							stepping_back <= 1'b0;
							state         <= phase_align_pkg::DECIDE;
						end
						else
							measure_start <= 1'b1;
					end
				end

				default: state <= phase_align_pkg::IDLE;

			endcase
		end
	end

	// Result latch
	always_ff @(posedge clk_312p5mhz) begin
		if (window_result.valid &&
			(state == phase_align_pkg::MEASURE || state == phase_align_pkg::ALIGNED))
			result_q <= window_result.meas;
	end

	//////////////////////////////////////////////////////////////////////
	// Checks

	// Shift sent to the MMCM and not yet answered
	logic shift_pending;

	always_ff @(posedge clk_312p5mhz) begin
		if (serdes_rst)
			shift_pending <= 1'b0;
		else if (phase_shift.en)
			shift_pending <= 1'b1;
		else if (phase_shift_done)
			shift_pending <= 1'b0;
	end

	// One shift in flight, next en only after the MMCM answers
	a_shift_handshake: assert property (@(posedge clk_312p5mhz)
		disable iff (serdes_rst)
		phase_shift.en |-> !shift_pending);

	// Eye width must fit the bump counter
	a_bump_no_wrap: assert property (@(posedge clk_312p5mhz)
		disable iff (serdes_rst)
		(bump_cnt == '0) |-> ($past(bump_cnt) != '1));

	// Lock flag only while aligned
	a_done_only_aligned: assert property (@(posedge clk_312p5mhz)
		disable iff (serdes_rst)
		(state != phase_align_pkg::ALIGNED) |-> !done);

endmodule

// ==== src/oversampling_phase_align.sv ====
`timescale 1ns/1ps

module oversampling_phase_align(
	input wire                                    clk_312p5mhz,
	input wire                                    serdes_rst,

	// Captured loopback word from the deserializer
	input wire [phase_align_pkg::WORD_WIDTH-1:0]  loopback_word,

	// MMCM dynamic phase shift port
	output wire phase_align_pkg::phase_shift_cmd_t phase_shift,
	input wire                                    phase_shift_done,

	// High while the fabric clock sits mid-eye
	output wire                                   done
);

	//////////////////////////////////////////////////////////////////////
	// Internal links

	// Window request from the search FSM
	wire measure_start;

	// Window verdict back from the checker
	wire phase_align_pkg::window_result_t window_result;

	//////////////////////////////////////////////////////////////////////
	// Loopback stability measurement

	word_stability_checker u_checker(
		.clk_312p5mhz  (clk_312p5mhz),
		.serdes_rst    (serdes_rst),
		.loopback_word (loopback_word),
		.measure_start (measure_start),
		.window_result (window_result)
	);

	//////////////////////////////////////////////////////////////////////
	// Edge search and step-back

	phase_search_fsm u_search(
		.clk_312p5mhz     (clk_312p5mhz),
		.serdes_rst       (serdes_rst),
		.window_result    (window_result),
		.phase_shift_done (phase_shift_done),
		.measure_start    (measure_start),
		.phase_shift      (phase_shift),
		.done             (done)
	);

endmodule

// ==== test/loopback_phase_model.sv ====
`timescale 1ns/1ps

module loopback_phase_model(
	input wire                                    clk_312p5mhz,
	input wire                                    serdes_rst,

	// Phase shift port, as the MMCM sees it
	input wire                                    shift_en,
	input wire                                    shift_inc,
	output logic                                  shift_done,

	// Response delay for the next shift, 4 to 12 cycles
	input wire [3:0]                              shift_delay,

	// Forced move of the sampling phase
	input wire                                    jump_en,
	input wire [15:0]                             jump_pos,

	// Word seen by the deserializer at the current phase
	output logic [phase_align_pkg::WORD_WIDTH-1:0] loopback_word
);

	// Sixteen phase steps per bit period
	localparam int STEPS_PER_BIT = 16;

	// Sampling phase in steps
	int position;

	// Inputs sampled mid-cycle
	logic en_s;
	logic inc_s;
	logic jump_s;
	logic [15:0] jump_pos_s;
	logic [3:0] delay_s;

	// Shift in flight
	logic busy;
	logic dir_inc;
	int   wait_cnt;

	// Marker bit from the phase, two bits set near the bit edge
	function automatic logic [3:0] word_at(input int pos);
		int idx;
		int frac;
		begin
			idx  = (pos / STEPS_PER_BIT) % 4;
			frac = pos % STEPS_PER_BIT;
			if (frac < 2)
				word_at = (4'b0001 << idx) | (4'b0001 << ((idx + 1) % 4));
			else
				word_at = 4'b0001 << idx;
		end
	endfunction

	initial begin
		position      = 64;
		busy          = 1'b0;
		dir_inc       = 1'b1;
		wait_cnt      = 0;
		shift_done    = 1'b0;
		loopback_word = word_at(64);
		forever begin
			// Sample everything where it is settled
			@(negedge clk_312p5mhz);
			en_s       = shift_en;
			inc_s      = shift_inc;
			jump_s     = jump_en;
			jump_pos_s = jump_pos;
			delay_s    = shift_delay;

			// Act just after the next rising edge
			@(posedge clk_312p5mhz);
			#1;
			shift_done = 1'b0;
			if (jump_s)
				position = int'(jump_pos_s);
			if (serdes_rst) begin
				busy = 1'b0;
			end
			else if (en_s) begin
				busy     = 1'b1;
				dir_inc  = inc_s;
				wait_cnt = delay_s - 1;
			end
			else if (busy) begin
				wait_cnt = wait_cnt - 1;
				// Phase moves when the MMCM reports completion
				if (wait_cnt <= 0) begin
					position   = dir_inc ? position + 1 : position - 1;
					shift_done = 1'b1;
					busy       = 1'b0;
				end
			end
			loopback_word = word_at(position);
		end
	end

endmodule

// ==== test/tb_phase_align.sv ====
`timescale 1ns/1ps

module tb_phase_align;

	// 3 resets, each aligned twice, about 40 steps of 50 cycles each
	localparam int ALIGNMENTS  = 6;
	localparam int MAX_CYCLES  = ALIGNMENTS * 40 * 50 + 8000;

	// Start pulse on the second cycle out of reset,
	// result 34 cycles later, first shift one cycle after that
	localparam int FIRST_EN_CYCLE = 2 + (phase_align_pkg::MEASURE_CYCLES + 2) + 1;

	logic clk_312p5mhz;
	logic serdes_rst;
	logic [phase_align_pkg::WORD_WIDTH-1:0] loopback_word;
	logic phase_shift_done;
	logic done;
	phase_align_pkg::phase_shift_cmd_t phase_shift;

	logic [3:0]  shift_delay;
	logic        jump_en;
	logic [15:0] jump_pos;

	logic [31:0] lfsr;
	int errors;
	int cycles;
	int aligned_cnt;
	int since_rst;
	logic first_en_seen;
	logic in_flight;
	logic done_prev;

	// Reference copy of the search rule
	logic ref_first;
	logic ref_seen;
	logic ref_back;
	int   ref_bump;
	int   ref_decs;
	int   ref_edge;
	int   target;
	int   pos;
	logic exp_inc;

	int shift_delay_i;
	int run;
	int start;

	oversampling_phase_align u_dut(
		.clk_312p5mhz     (clk_312p5mhz),
		.serdes_rst       (serdes_rst),
		.loopback_word    (loopback_word),
		.phase_shift      (phase_shift),
		.phase_shift_done (phase_shift_done),
		.done             (done)
	);

	loopback_phase_model u_model(
		.clk_312p5mhz  (clk_312p5mhz),
		.serdes_rst    (serdes_rst),
		.shift_en      (phase_shift.en),
		.shift_inc     (phase_shift.inc),
		.shift_done    (phase_shift_done),
		.shift_delay   (shift_delay),
		.jump_en       (jump_en),
		.jump_pos      (jump_pos),
		.loopback_word (loopback_word)
	);

	initial begin
		clk_312p5mhz = 1'b0;
		forever #100 clk_312p5mhz = ~clk_312p5mhz;
	end

	//////////////////////////////////////////////////////////////////////
	// Random source

	// Galois LFSR, one step per bit
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		lfsr_step = s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
	endfunction

	task automatic rand_bits(input int n, output int val);
		int i;
		begin
			val = 0;
			for (i = 0; i < n; i++) begin
				lfsr = lfsr_step(lfsr);
				val  = (val << 1) | int'(lfsr[0]);
			end
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// Checking, sampled on the falling edge

	always @(negedge clk_312p5mhz) begin
		if (serdes_rst) begin
			since_rst     = 0;
			first_en_seen = 1'b0;
			in_flight     = 1'b0;
			ref_first     = 1'b0;
			ref_seen      = 1'b0;
			ref_back      = 1'b0;
			ref_bump      = 0;
			ref_decs      = 0;
		end
		else begin
			since_rst++;
			pos = u_model.position;

			// Nothing moves before the first window has been judged
			if (!first_en_seen) begin
				assert (done == 1'b0) else begin
					errors++;
					$display("ERROR t=%0t done exp=0 act=%0b", $time, done);
				end
			end
			if (phase_shift.en && !first_en_seen) begin
				first_en_seen = 1'b1;
				assert (since_rst == FIRST_EN_CYCLE) else begin
					errors++;
					$display("ERROR t=%0t first_shift_cycle exp=%0d act=%0d",
						$time, FIRST_EN_CYCLE, since_rst);
				end
			end

			if (phase_shift_done) begin
				assert (in_flight) else begin
					errors++;
					$display("Shift done pulse with no shift pending");
				end
				in_flight = 1'b0;
			end

			if (phase_shift.en) begin
				assert (!in_flight) else begin
					errors++;
					$display("New shift issued before the previous one completed");
				end
				in_flight = 1'b1;

				// Apply the search rule to the phase just measured
				if (ref_back) begin
					exp_inc = 1'b0;
					ref_decs++;
				end
				else if (pos % 16 >= 2) begin
					exp_inc = 1'b1;
					ref_bump++;
					ref_seen = 1'b1;
				end
				else if (ref_first && ref_seen) begin
					exp_inc  = 1'b0;
					ref_edge = pos;
					ref_decs = 1;
					ref_back = 1'b1;
				end
				else begin
					exp_inc   = 1'b1;
					ref_first = 1'b1;
					ref_seen  = 1'b0;
					ref_bump  = 1;
				end
				assert (phase_shift.inc == exp_inc) else begin
					errors++;
					$display("ERROR t=%0t phase_shift.inc exp=%0b act=%0b",
						$time, exp_inc, phase_shift.inc);
				end
			end

			// Lock reached, phase must sit mid-eye
			if (done && !done_prev) begin
				aligned_cnt++;
				assert (ref_back && !in_flight) else begin
					errors++;
					$display("Done rose before the second edge or with a shift pending");
				end
				assert (ref_decs == ref_bump / 2) else begin
					errors++;
					$display("ERROR t=%0t decrement_shifts exp=%0d act=%0d",
						$time, ref_bump / 2, ref_decs);
				end
				target = ref_edge - ref_bump / 2;
				assert (pos == target) else begin
					errors++;
					$display("ERROR t=%0t position exp=%0d act=%0d", $time, target, pos);
				end
				assert (pos % 16 == 8 || pos % 16 == 9) else begin
					errors++;
					$display("ERROR t=%0t position_mod16 exp=8or9 act=%0d",
						$time, pos % 16);
				end
				// A loss of lock starts a fresh search
				ref_first = 1'b0;
				ref_seen  = 1'b0;
				ref_back  = 1'b0;
			end

			// Lock drops only on a window at a bit edge, with its first shift
			if (!done && done_prev) begin
				assert (phase_shift.en) else begin
					errors++;
					$display("Done fell without a shift for the window that lost lock");
				end
				assert (pos % 16 < 2) else begin
					errors++;
					$display("ERROR t=%0t position_mod16 exp=0or1 act=%0d",
						$time, pos % 16);
				end
			end
		end
		done_prev = done;
	end

	//////////////////////////////////////////////////////////////////////
	// Timeout

	always @(posedge clk_312p5mhz) begin
		cycles++;
		if (cycles >= MAX_CYCLES) begin
			$display("Run stopped at the cycle limit, alignment never finished");
			$display("errors=%0d", errors + 1);
			$display("Some tests failed");
			$finish;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Stimulus

	// Reset with the model parked at a start phase
	task automatic start_from(input int start);
		begin
			@(posedge clk_312p5mhz);
			#1;
			serdes_rst = 1'b1;
			jump_en    = 1'b1;
			jump_pos   = 16'(start);
			repeat (3) @(posedge clk_312p5mhz);
			#1;
			serdes_rst = 1'b0;
			jump_en    = 1'b0;
		end
	endtask

	// Push the phase onto a bit edge while locked
	task automatic disturb_lock();
		int p;
		begin
			@(posedge clk_312p5mhz);
			#1;
			p        = u_model.position;
			jump_en  = 1'b1;
			jump_pos = 16'((p / 16 + 1) * 16);
			@(posedge clk_312p5mhz);
			#1;
			jump_en = 1'b0;
		end
	endtask

	task automatic wait_done(input logic level);
		begin
			while (done !== level) begin
				@(posedge clk_312p5mhz);
				#1;
				rand_bits(4, shift_delay_i);
				shift_delay = 4'(4 + shift_delay_i % 9);
			end
		end
	endtask

	initial begin
		serdes_rst  = 1'b1;
		shift_delay = 4'd4;
		jump_en     = 1'b0;
		jump_pos    = 16'd64;
		lfsr        = 32'h7895;
		errors      = 0;
		cycles      = 0;
		aligned_cnt = 0;
		done_prev   = 1'b0;

		for (run = 0; run < 3; run++) begin
			rand_bits(6, start);
			start = 64 + start;
			// Second run starts on a bit edge, two unstable windows in a row
			if (run == 1)
				start = start - start % 16;
			start_from(start);
			wait_done(1'b1);
			disturb_lock();
			wait_done(1'b0);
			wait_done(1'b1);
			repeat (5) @(posedge clk_312p5mhz);
		end

		assert (aligned_cnt == ALIGNMENTS) else begin
			errors++;
			$display("ERROR t=%0t aligned_cnt exp=%0d act=%0d",
				$time, ALIGNMENTS, aligned_cnt);
		end

		$display("errors=%0d alignments=%0d", errors, aligned_cnt);
		if (errors == 0)
			$display("All tests passed");
		else
			$display("Some tests failed");
		$finish;
	end

endmodule

// ==== tb.f ====
common/phase_align_pkg.sv
phase_align/word_stability_checker.sv
phase_align/phase_search_fsm.sv
src/oversampling_phase_align.sv
test/loopback_phase_model.sv
test/tb_phase_align.sv

// ==== Makefile ====
# Verilator build and run for the phase alignment testbench

VERILATOR   ?= verilator
TOP         ?= tb_phase_align
FILELIST    ?= tb.f
OBJ_DIR     ?= obj_dir
LOG         ?= sim.log
VFLAGS      ?= --binary --timing --assert -j 0
FAIL_MSG    ?= Some tests failed
PASS_MSG    ?= All tests passed

BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# Fails if the fail message is in the log or the pass message is missing
run: $(BIN)
	./$(BIN) > $(LOG) 2>&1; true
	cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "Simulation failed"; exit 1; \
	fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "Simulation did not finish cleanly"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
